// ==== source/bypass_macros.svh ====
`ifndef BYPASS_MACROS_SVH
`define BYPASS_MACROS_SVH

////////////////////
// Register file geometry seen by the ID stage
////////////////////

// Number of register file read ports used by an instruction in ID
// Port 0 carries rs1 and port 1 carries rs2
`define BYP_NUM_READ_PORTS 2

// Width of a register index
// Index zero is the hardwired x0 and never takes part in a hazard
`define BYP_RF_ADDR_W 5

`endif

// ==== source/bypass_pkg.sv ====
`include "bypass_macros.svh"

package bypass_pkg;

  ////////////////////
  // Register file types
  ////////////////////

  // Register index as decoded from rs1, rs2 or rd
  typedef logic [`BYP_RF_ADDR_W-1:0] rf_addr_t;

  // One bit per read port, bit 0 is rs1 and bit 1 is rs2
  typedef logic [`BYP_NUM_READ_PORTS-1:0] rd_port_t;

  ////////////////////
  // Forwarding mux selects
  ////////////////////

  // Source of an ALU operand in ID
  // The encoding leaves 2'b11 free for a later extra source
  typedef enum logic [1:0] {
    FW_SEL_REGFILE = 2'b00,
    FW_SEL_EX      = 2'b01,
    FW_SEL_WB      = 2'b10
  } fw_sel_e;

  // Source of the jump target base on the jump-register path
  // Only an ALU result in WB can be forwarded here
  typedef enum logic {
    JALR_SEL_REGFILE = 1'b0,
    JALR_SEL_WB      = 1'b1
  } jalr_fw_sel_e;

endpackage

// ==== source/pipe_qualify.sv ====
`timescale 1ns/1ns

module pipe_qualify (
  // ID stage
  input  logic instr_valid_id_i,
  input  logic jalr_id_i,
  input  logic csr_en_id_i,
  input  logic mret_id_i,
  input  logic wfi_id_i,
  input  logic fetch_err_id_i,
  input  logic trigger_match_id_i,

  // EX stage
  input  logic instr_valid_ex_i,
  input  logic rf_we_ex_i,
  input  logic lsu_en_ex_i,
  input  logic csr_en_ex_i,
  input  logic mret_ex_i,
  input  logic wfi_ex_i,

  // WB stage
  input  logic instr_valid_wb_i,
  input  logic rf_we_wb_i,
  input  logic lsu_en_wb_i,
  input  logic csr_en_wb_i,
  input  logic mret_wb_i,

  // Qualified flags
  output logic we_ex_o,
  output logic we_wb_o,
  output logic load_ex_o,
  output logic load_wb_o,
  output logic jalr_id_o,
  output logic csr_read_id_o,
  output logic csr_write_ex_wb_o,
  output logic wfi_ex_o,
  output logic deassert_we_o
);

  ////////////////////
  // Register file writers
  ////////////////////

  // A stage only writes the register file while it holds a valid instruction
  assign we_ex_o   = rf_we_ex_i  && instr_valid_ex_i;
  assign we_wb_o   = rf_we_wb_i  && instr_valid_wb_i;

  // Loads are the LSU instructions, their data is late in both stages
  assign load_ex_o = lsu_en_ex_i && instr_valid_ex_i;
  assign load_wb_o = lsu_en_wb_i && instr_valid_wb_i;

  ////////////////////
  // ID stage and CSR traffic
  ////////////////////

  assign jalr_id_o = jalr_id_i && instr_valid_id_i;

  // WFI reads mstatus and the privilege level, MRET reads mepc and mstatus
  assign csr_read_id_o = instr_valid_id_i && (csr_en_id_i || mret_id_i || wfi_id_i);

  // MRET writes mstatus as a side effect, so it counts as a CSR write too
  assign csr_write_ex_wb_o = (instr_valid_ex_i && (csr_en_ex_i || mret_ex_i)) ||
                             (instr_valid_wb_i && (csr_en_wb_i || mret_wb_i));

  // A WFI in EX holds back everything behind it
  assign wfi_ex_o = wfi_ex_i && instr_valid_ex_i;

  // Faulted instructions travel on as a NOP, their write enables are dropped
  // A trigger hit also drops them so nothing executes before debug entry
  assign deassert_we_o = instr_valid_id_i && (fetch_err_id_i || trigger_match_id_i);

endmodule

// ==== source/reg_hazard_match.sv ====
`timescale 1ns/1ns
`include "bypass_macros.svh"

module reg_hazard_match (
  // Source operands decoded in ID
  input  bypass_pkg::rd_port_t rf_re_id_i,
  input  bypass_pkg::rf_addr_t rf_raddr_a_id_i,
  input  bypass_pkg::rf_addr_t rf_raddr_b_id_i,

  // Destination registers of the later stages
  input  bypass_pkg::rf_addr_t rf_waddr_ex_i,
  input  bypass_pkg::rf_addr_t rf_waddr_wb_i,

  // Address matches, not yet qualified with the stage write enables
  output bypass_pkg::rd_port_t ex_match_o,
  output bypass_pkg::rd_port_t wb_match_o,
  output logic                 jalr_ex_match_o,
  output logic                 jalr_wb_match_o
);

  import bypass_pkg::*;

  // Read addresses indexed by port so the compare can loop over them
  rf_addr_t rf_raddr [`BYP_NUM_READ_PORTS];

  assign rf_raddr[0] = rf_raddr_a_id_i;
  assign rf_raddr[1] = rf_raddr_b_id_i;

  ////////////////////
  // Operand ports
  ////////////////////

  // Reads of x0 return zero, so a write to x0 is never a hazard
  for (genvar i = 0; i < `BYP_NUM_READ_PORTS; i++) begin : gen_port_match
    assign ex_match_o[i] = rf_re_id_i[i] && (|rf_raddr[i]) &&
                           (rf_raddr[i] == rf_waddr_ex_i);
    assign wb_match_o[i] = rf_re_id_i[i] && (|rf_raddr[i]) &&
                           (rf_raddr[i] == rf_waddr_wb_i);
  end

  ////////////////////
  // Jump-register base
  ////////////////////

  // A jump-register always reads rs1, so the read enable is left out here
  assign jalr_ex_match_o = (|rf_raddr_a_id_i) && (rf_raddr_a_id_i == rf_waddr_ex_i);
  assign jalr_wb_match_o = (|rf_raddr_a_id_i) && (rf_raddr_a_id_i == rf_waddr_wb_i);

endmodule

// ==== source/stall_detect.sv ====
`timescale 1ns/1ns

module stall_detect (
  // Qualified stage flags
  input  logic                 we_ex_i,
  input  logic                 we_wb_i,
  input  logic                 load_ex_i,
  input  logic                 load_wb_i,
  input  logic                 jalr_id_i,
  input  logic                 csr_read_id_i,
  input  logic                 csr_write_ex_wb_i,
  input  logic                 wfi_ex_i,

  // WB has its data, a load still waiting on the bus holds this low
  input  logic                 wb_ready_i,

  // Address matches against the EX and WB destinations
  input  logic                 jalr_ex_match_i,
  input  logic                 jalr_wb_match_i,
  input  bypass_pkg::rd_port_t ex_match_i,
  input  bypass_pkg::rd_port_t wb_match_i,

  // Stall requests for ID
  output logic                 load_stall_o,
  output logic                 jalr_stall_o,
  output logic                 csr_stall_o,
  output logic                 wfi_stall_o
);

  ////////////////////
  // Load-use hazard
  ////////////////////

  // Load data only exists once WB is done, so an EX load cannot forward
  // While WB waits on the bus its result is not there yet either
  assign load_stall_o = (load_ex_i && we_ex_i && (|ex_match_i)) ||
                        (!wb_ready_i && we_wb_i && (|wb_match_i));

  ////////////////////
  // Jump-register hazard
  ////////////////////

  // The jump target path has no EX forward at all
  // From WB only an ALU result is forwarded, load data would be too late
  assign jalr_stall_o = jalr_id_i &&
                        ((we_ex_i && jalr_ex_match_i) ||
                         (we_wb_i && jalr_wb_match_i && load_wb_i));

  ////////////////////
  // CSR and WFI
  ////////////////////

  // CSR reads in ID wait until no CSR write is left in EX or WB
  // This is coarse on purpose and ignores the CSR address
  assign csr_stall_o = csr_read_id_i && csr_write_ex_wb_i;

  // Nothing may follow a WFI while it sits in EX
  assign wfi_stall_o = wfi_ex_i;

endmodule

// ==== source/forward_select.sv ====
`timescale 1ns/1ns

module forward_select (
  // Qualified stage write enables
  input  logic                     we_ex_i,
  input  logic                     we_wb_i,

  // Address matches from the hazard compare
  input  logic                     jalr_wb_match_i,
  input  bypass_pkg::rd_port_t     ex_match_i,
  input  bypass_pkg::rd_port_t     wb_match_i,

  // Mux selects for the ID operand paths
  output bypass_pkg::fw_sel_e      op_a_fw_sel_o,
  output bypass_pkg::fw_sel_e      op_b_fw_sel_o,
  output bypass_pkg::jalr_fw_sel_e jalr_fw_sel_o
);

  import bypass_pkg::*;

  // Picks the source for one operand port
  // EX holds the youngest value and so beats WB when both write the register
  function automatic fw_sel_e operand_sel(input logic ex_we, input logic ex_hit,
                                          input logic wb_we, input logic wb_hit);
    fw_sel_e sel;
    sel = FW_SEL_REGFILE;
    if (wb_we && wb_hit) begin
      sel = FW_SEL_WB;
    end
    if (ex_we && ex_hit) begin
      sel = FW_SEL_EX;
    end
    return sel;
  endfunction

  ////////////////////
  // Operand muxes
  ////////////////////

  // An EX select during a load is harmless since load_stall holds ID anyway
  assign op_a_fw_sel_o = operand_sel(we_ex_i, ex_match_i[0], we_wb_i, wb_match_i[0]);
  assign op_b_fw_sel_o = operand_sel(we_ex_i, ex_match_i[1], we_wb_i, wb_match_i[1]);

  ////////////////////
  // Jump-register mux
  ////////////////////

  // Load results in WB also pick WB here, but then jalr_stall holds ID
  always_comb begin
    jalr_fw_sel_o = JALR_SEL_REGFILE;
    if (we_wb_i && jalr_wb_match_i) begin
      jalr_fw_sel_o = JALR_SEL_WB;
    end
  end

endmodule

// ==== source/bypass_ctrl.sv ====
`timescale 1ns/1ns

module bypass_ctrl (
  // ID stage
  input  logic                     instr_valid_id_i,
  input  bypass_pkg::rd_port_t     rf_re_id_i,
  input  bypass_pkg::rf_addr_t     rf_raddr_a_id_i,
  input  bypass_pkg::rf_addr_t     rf_raddr_b_id_i,
  input  logic                     jalr_id_i,
  input  logic                     csr_en_id_i,
  input  logic                     mret_id_i,
  input  logic                     wfi_id_i,
  input  logic                     fetch_err_id_i,
  input  logic                     trigger_match_id_i,

  // EX stage
  input  logic                     instr_valid_ex_i,
  input  logic                     rf_we_ex_i,
  input  bypass_pkg::rf_addr_t     rf_waddr_ex_i,
  input  logic                     lsu_en_ex_i,
  input  logic                     csr_en_ex_i,
  input  logic                     mret_ex_i,
  input  logic                     wfi_ex_i,

  // WB stage
  input  logic                     instr_valid_wb_i,
  input  logic                     rf_we_wb_i,
  input  bypass_pkg::rf_addr_t     rf_waddr_wb_i,
  input  logic                     lsu_en_wb_i,
  input  logic                     csr_en_wb_i,
  input  logic                     mret_wb_i,
  input  logic                     wb_ready_i,

  // Stall, deassert and forwarding controls
  output logic                     load_stall_o,
  output logic                     jalr_stall_o,
  output logic                     csr_stall_o,
  output logic                     wfi_stall_o,
  output logic                     deassert_we_o,
  output bypass_pkg::fw_sel_e      op_a_fw_sel_o,
  output bypass_pkg::fw_sel_e      op_b_fw_sel_o,
  output bypass_pkg::jalr_fw_sel_e jalr_fw_sel_o
);

  import bypass_pkg::*;

  // Stage flags after qualification with instr_valid
  logic     we_ex;
  logic     we_wb;
  logic     load_ex;
  logic     load_wb;
  logic     jalr_id;
  logic     csr_read_id;
  logic     csr_write_ex_wb;
  logic     wfi_ex;

  // Raw address compares between ID and the later stages
  rd_port_t ex_match;
  rd_port_t wb_match;
  logic     jalr_ex_match;
  logic     jalr_wb_match;

  ////////////////////
  // Decode side
  ////////////////////

  pipe_qualify u_pipe_qualify (
    .instr_valid_id_i   (instr_valid_id_i),
    .jalr_id_i          (jalr_id_i),
    .csr_en_id_i        (csr_en_id_i),
    .mret_id_i          (mret_id_i),
    .wfi_id_i           (wfi_id_i),
    .fetch_err_id_i     (fetch_err_id_i),
    .trigger_match_id_i (trigger_match_id_i),
    .instr_valid_ex_i   (instr_valid_ex_i),
    .rf_we_ex_i         (rf_we_ex_i),
    .lsu_en_ex_i        (lsu_en_ex_i),
    .csr_en_ex_i        (csr_en_ex_i),
    .mret_ex_i          (mret_ex_i),
    .wfi_ex_i           (wfi_ex_i),
    .instr_valid_wb_i   (instr_valid_wb_i),
    .rf_we_wb_i         (rf_we_wb_i),
    .lsu_en_wb_i        (lsu_en_wb_i),
    .csr_en_wb_i        (csr_en_wb_i),
    .mret_wb_i          (mret_wb_i),
    .we_ex_o            (we_ex),
    .we_wb_o            (we_wb),
    .load_ex_o          (load_ex),
    .load_wb_o          (load_wb),
    .jalr_id_o          (jalr_id),
    .csr_read_id_o      (csr_read_id),
    .csr_write_ex_wb_o  (csr_write_ex_wb),
    .wfi_ex_o           (wfi_ex),
    .deassert_we_o      (deassert_we_o)
  );

  ////////////////////
  // Hazard compare and stalls
  ////////////////////

  reg_hazard_match u_reg_hazard_match (
    .rf_re_id_i      (rf_re_id_i),
    .rf_raddr_a_id_i (rf_raddr_a_id_i),
    .rf_raddr_b_id_i (rf_raddr_b_id_i),
    .rf_waddr_ex_i   (rf_waddr_ex_i),
    .rf_waddr_wb_i   (rf_waddr_wb_i),
    .ex_match_o      (ex_match),
    .wb_match_o      (wb_match),
    .jalr_ex_match_o (jalr_ex_match),
    .jalr_wb_match_o (jalr_wb_match)
  );

  stall_detect u_stall_detect (
    .we_ex_i           (we_ex),
    .we_wb_i           (we_wb),
    .load_ex_i         (load_ex),
    .load_wb_i         (load_wb),
    .jalr_id_i         (jalr_id),
    .csr_read_id_i     (csr_read_id),
    .csr_write_ex_wb_i (csr_write_ex_wb),
    .wfi_ex_i          (wfi_ex),
    .wb_ready_i        (wb_ready_i),
    .jalr_ex_match_i   (jalr_ex_match),
    .jalr_wb_match_i   (jalr_wb_match),
    .ex_match_i        (ex_match),
    .wb_match_i        (wb_match),
    .load_stall_o      (load_stall_o),
    .jalr_stall_o      (jalr_stall_o),
    .csr_stall_o       (csr_stall_o),
    .wfi_stall_o       (wfi_stall_o)
  );

  ////////////////////
  // Result side
  ////////////////////

  forward_select u_forward_select (
    .we_ex_i         (we_ex),
    .we_wb_i         (we_wb),
    .jalr_wb_match_i (jalr_wb_match),
    .ex_match_i      (ex_match),
    .wb_match_i      (wb_match),
    .op_a_fw_sel_o   (op_a_fw_sel_o),
    .op_b_fw_sel_o   (op_b_fw_sel_o),
    .jalr_fw_sel_o   (jalr_fw_sel_o)
  );

endmodule

// ==== verification/bypass_vectors.svh ====
`ifndef BYPASS_VECTORS_SVH
`define BYPASS_VECTORS_SVH

////////////////////
// Stimulus and expected outputs, one row per clock
////////////////////

// Columns are name, ID flags, rs1, rs2, EX flags, EX rd, WB flags, WB rd, expected
// ID flags are valid, read enable rs2 rs1, jalr csr mret wfi, fetch error trigger
// EX flags are valid write, lsu csr mret wfi and WB flags end in wb_ready instead
// Expected is load jalr csr wfi deassert, op A select, op B select, jalr select
task automatic build_table();
  add_row("idle",        9'b0_00_0000_00, 0, 0, 6'b00_0000, 0, 6'b00_0001, 0, 10'b00000_00_00_0);
  add_row("all_invld",   9'b0_11_1111_11, 3, 3, 6'b01_1111, 3, 6'b01_1110, 3, 10'b00000_00_00_0);
  // Operand forwarding
  add_row("ex_a",        9'b1_01_0000_00, 3, 0, 6'b11_0000, 3, 6'b00_0001, 0, 10'b00000_01_00_0);
  add_row("ex_b",        9'b1_10_0000_00, 0, 7, 6'b11_0000, 7, 6'b00_0001, 0, 10'b00000_00_01_0);
  add_row("wb_a",        9'b1_01_0000_00, 5, 0, 6'b11_0000, 6, 6'b11_0001, 5, 10'b00000_10_00_1);
  add_row("wb_b",        9'b1_10_0000_00, 0, 4, 6'b00_0000, 0, 6'b11_0001, 4, 10'b00000_00_10_0);
  add_row("ex_wins",     9'b1_11_0000_00, 8, 8, 6'b11_0000, 8, 6'b11_0001, 8, 10'b00000_01_01_1);
  add_row("x0_read",     9'b1_11_0000_00, 0, 0, 6'b11_0000, 0, 6'b11_0001, 0, 10'b00000_00_00_0);
  // The jump path ignores the read enables, so its select still follows WB
  add_row("re_low",      9'b1_00_0000_00, 4, 4, 6'b11_0000, 4, 6'b11_0001, 4, 10'b00000_00_00_1);
  // Load-use
  add_row("ld_ex_a",     9'b1_01_0000_00, 6, 0, 6'b11_1000, 6, 6'b00_0001, 0, 10'b10000_01_00_0);
  add_row("ld_ex_b",     9'b1_10_0000_00, 0, 7, 6'b11_1000, 7, 6'b00_0001, 0, 10'b10000_00_01_0);
  add_row("ld_ex_miss",  9'b1_01_0000_00, 2, 0, 6'b11_1000, 3, 6'b00_0001, 0, 10'b00000_00_00_0);
  add_row("wb_wait",     9'b1_01_0000_00, 2, 0, 6'b00_0000, 0, 6'b11_1000, 2, 10'b10000_10_00_1);
  add_row("wb_ready",    9'b1_01_0000_00, 2, 0, 6'b00_0000, 0, 6'b11_1001, 2, 10'b00000_10_00_1);
  // Jump-register base
  add_row("jalr_ex",     9'b1_01_1000_00, 3, 0, 6'b11_0000, 3, 6'b00_0001, 0, 10'b01000_01_00_0);
  add_row("jalr_re0",    9'b1_00_1000_00, 3, 0, 6'b11_0000, 3, 6'b00_0001, 0, 10'b01000_00_00_0);
  add_row("jalr_wb_ld",  9'b1_01_1000_00, 5, 0, 6'b00_0000, 0, 6'b11_1001, 5, 10'b01000_10_00_1);
  add_row("jalr_wb_alu", 9'b1_01_1000_00, 5, 0, 6'b00_0000, 0, 6'b11_0001, 5, 10'b00000_10_00_1);
  // CSR and WFI
  add_row("csr_ex",      9'b1_00_0100_00, 0, 0, 6'b10_0100, 0, 6'b00_0001, 0, 10'b00100_00_00_0);
  add_row("mret_wb",     9'b1_00_0010_00, 0, 0, 6'b00_0000, 0, 6'b10_0011, 0, 10'b00100_00_00_0);
  add_row("wfi_csr_wb",  9'b1_00_0001_00, 0, 0, 6'b00_0000, 0, 6'b10_0101, 0, 10'b00100_00_00_0);
  add_row("mret_ex",     9'b1_00_0100_00, 0, 0, 6'b10_0010, 0, 6'b00_0001, 0, 10'b00100_00_00_0);
  add_row("csr_ex_inv",  9'b1_00_0100_00, 0, 0, 6'b00_0110, 0, 6'b00_0001, 0, 10'b00000_00_00_0);
  add_row("csr_id_inv",  9'b0_00_0100_00, 0, 0, 6'b10_0100, 0, 6'b00_0001, 0, 10'b00000_00_00_0);
  add_row("wfi_ex",      9'b0_00_0000_00, 0, 0, 6'b10_0001, 0, 6'b00_0001, 0, 10'b00010_00_00_0);
  add_row("wfi_ex_inv",  9'b0_00_0000_00, 0, 0, 6'b00_0001, 0, 6'b00_0001, 0, 10'b00000_00_00_0);
  // Faulted instructions in ID
  add_row("fetch_err",   9'b1_00_0000_10, 0, 0, 6'b00_0000, 0, 6'b00_0001, 0, 10'b00001_00_00_0);
  add_row("trig_match",  9'b1_00_0000_01, 0, 0, 6'b00_0000, 0, 6'b00_0001, 0, 10'b00001_00_00_0);
  add_row("fault_inv",   9'b0_00_0000_11, 0, 0, 6'b00_0000, 0, 6'b00_0001, 0, 10'b00000_00_00_0);
  add_row("idle_end",    9'b0_00_0000_00, 0, 0, 6'b00_0000, 0, 6'b00_0001, 0, 10'b00000_00_00_0);
endtask

`endif

// ==== verification/bypass_ctrl_tb.sv ====
`timescale 1ns/1ns

module bypass_ctrl_tb;

  import bypass_pkg::*;

  // One table row with the flag groups kept in their packed form
  typedef struct packed {
    logic [8:0]   id_flags;
    rf_addr_t     raddr_a;
    rf_addr_t     raddr_b;
    logic [5:0]   ex_flags;
    rf_addr_t     waddr_ex;
    logic [5:0]   wb_flags;
    rf_addr_t     waddr_wb;
    logic [4:0]   exp_stall;
    fw_sel_e      exp_a;
    fw_sel_e      exp_b;
    jalr_fw_sel_e exp_j;
  } vector_t;

  logic clk;
  logic reset_i;

  // DUT inputs
  logic instr_valid_id_i, jalr_id_i, csr_en_id_i, mret_id_i, wfi_id_i;
  logic fetch_err_id_i, trigger_match_id_i;
  rd_port_t rf_re_id_i;
  rf_addr_t rf_raddr_a_id_i, rf_raddr_b_id_i, rf_waddr_ex_i, rf_waddr_wb_i;
  logic instr_valid_ex_i, rf_we_ex_i, lsu_en_ex_i, csr_en_ex_i, mret_ex_i, wfi_ex_i;
  logic instr_valid_wb_i, rf_we_wb_i, lsu_en_wb_i, csr_en_wb_i, mret_wb_i, wb_ready_i;

  // DUT outputs
  logic load_stall_o, jalr_stall_o, csr_stall_o, wfi_stall_o, deassert_we_o;
  fw_sel_e      op_a_fw_sel_o, op_b_fw_sel_o;
  jalr_fw_sel_e jalr_fw_sel_o;

  vector_t vectors[$];
  string   names[$];
  int      cycle_count = 0;
  int      cycle_limit = 0;

  bypass_ctrl u_dut (.*);

  always #50 clk = ~clk;

  task automatic add_row(input string name, input logic [8:0] id_flags,
                         input rf_addr_t raddr_a, input rf_addr_t raddr_b,
                         input logic [5:0] ex_flags, input rf_addr_t waddr_ex,
                         input logic [5:0] wb_flags, input rf_addr_t waddr_wb,
                         input logic [9:0] expected);
    vector_t v;
    v.id_flags  = id_flags;
    v.raddr_a   = raddr_a;
    v.raddr_b   = raddr_b;
    v.ex_flags  = ex_flags;
    v.waddr_ex  = waddr_ex;
    v.wb_flags  = wb_flags;
    v.waddr_wb  = waddr_wb;
    v.exp_stall = expected[9:5];
    v.exp_a     = fw_sel_e'(expected[4:3]);
    v.exp_b     = fw_sel_e'(expected[2:1]);
    v.exp_j     = jalr_fw_sel_e'(expected[0]);
    vectors.push_back(v);
    names.push_back(name);
  endtask

  `include "bypass_vectors.svh"

  // Unpacks one row onto the DUT pins
  task automatic apply_row(input vector_t v);
    {instr_valid_id_i, rf_re_id_i, jalr_id_i, csr_en_id_i} <= v.id_flags[8:4];
    {mret_id_i, wfi_id_i, fetch_err_id_i, trigger_match_id_i} <= v.id_flags[3:0];
    {instr_valid_ex_i, rf_we_ex_i, lsu_en_ex_i} <= v.ex_flags[5:3];
    {csr_en_ex_i, mret_ex_i, wfi_ex_i} <= v.ex_flags[2:0];
    {instr_valid_wb_i, rf_we_wb_i, lsu_en_wb_i} <= v.wb_flags[5:3];
    {csr_en_wb_i, mret_wb_i, wb_ready_i} <= v.wb_flags[2:0];
    rf_raddr_a_id_i <= v.raddr_a;
    rf_raddr_b_id_i <= v.raddr_b;
    rf_waddr_ex_i   <= v.waddr_ex;
    rf_waddr_wb_i   <= v.waddr_wb;
  endtask

  task automatic check_value(input string name, input logic [9:0] expected,
                             input logic [9:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %b, actual %b", name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "output mismatch in row %s", name);
    end
  endtask

  // Gathers every output in the same order as the expected column
  task automatic check_outputs(input string name, input logic [9:0] expected);
    logic [9:0] actual;
    actual = {load_stall_o, jalr_stall_o, csr_stall_o, wfi_stall_o, deassert_we_o,
              op_a_fw_sel_o, op_b_fw_sel_o, jalr_fw_sel_o};
    check_value(name, expected, actual);
  endtask

  ////////////////////
  // Cycle limit
  ////////////////////

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the table did not finish within %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped at the cycle limit");
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    clk = 1'b0;
    reset_i <= 1'b1;
    apply_row('0);
    build_table();
    cycle_limit = 5 + vectors.size() + 10;

    // Idle inputs must give idle outputs while reset is held
    repeat (5) begin
      @(posedge clk);
      @(negedge clk);
      check_outputs("reset", {5'b0, FW_SEL_REGFILE, FW_SEL_REGFILE, JALR_SEL_REGFILE});
    end

    // Each row goes in on a rising edge and is checked half a cycle later
    for (int i = 0; i < vectors.size(); i++) begin
      @(posedge clk);
      reset_i <= 1'b0;
      apply_row(vectors[i]);
      @(negedge clk);
      check_outputs(names[i], {vectors[i].exp_stall, vectors[i].exp_a,
                               vectors[i].exp_b, vectors[i].exp_j});
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+source
+incdir+verification
source/bypass_pkg.sv
source/pipe_qualify.sv
source/reg_hazard_match.sv
source/stall_detect.sv
source/forward_select.sv
source/bypass_ctrl.sv
verification/bypass_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module bypass_ctrl_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

output=$(./obj_dir/Vbypass_ctrl_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "NO ERRORS"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
